/* sources.f */
+incdir+design
design/rv_core_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/exec_unit.sv
design/exec_stage_top.sv
verification/exec_stage_asserts.sv
verification/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sources.f --top-module exec_stage_tb -o exec_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* verification/exec_stage_tb.sv */
`include "rv_core_params.svh"

`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_core_pkg::*;

    localparam int NUM_INSTR    = 2000;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // Three cycles per instruction leaves room for the random stalls
    localparam int TIMEOUT_NS   = (NUM_INSTR * 3 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        word_t    result;
        word_t    store_data;
        word_t    csr_wdata;
        reg_idx_t rd;
        logic     is_load;
        logic     is_store;
        logic     fence_i;
        logic     redirect_valid;
        word_t    redirect_pc;
        logic     halt;
        logic     illegal;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    word_t    inst;
    word_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    csr_rdata;
    logic     out_ready;
    logic     in_ready;
    logic     out_valid;
    word_t    result;
    word_t    store_data;
    word_t    csr_wdata;
    reg_idx_t rd;
    logic     is_load;
    logic     is_store;
    logic     fence_i;
    logic     redirect_valid;
    word_t    redirect_pc;
    logic     halt;
    logic     illegal;

    integer   seed    = 32'h8025_56ed;
    int       errors  = 0;
    int       checked = 0;
    int       sent;
    exp_t     exp_q[$];

    exec_stage_top exec_stage_top_inst (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .inst           (inst),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .csr_rdata      (csr_rdata),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .result         (result),
        .store_data     (store_data),
        .csr_wdata      (csr_wdata),
        .rd             (rd),
        .is_load        (is_load),
        .is_store       (is_store),
        .fence_i        (fence_i),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt           (halt),
        .illegal        (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t arith_ref(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = word_t'($signed(a) >>> b[4:0]);
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic exp_t expected_out(input word_t w, input word_t cur_pc, input word_t a,
                                          input word_t b, input word_t csr);
        exp_t       e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rd_field;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      tgt;
        logic       ok;
        opc      = w[6:0];
        f3       = w[14:12];
        f7       = w[31:25];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_s    = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u    = {w[31:12], 12'b0};
        imm_j    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        rd_field = (opc == `OPC_BRANCH || opc == `OPC_STORE) ? 5'd0 : w[11:7];
        ok       = 1'b1;
        e            = '0;
        e.store_data = b;
        e.rd         = rd_field;
        // Words without arithmetic of their own still add the two registers
        e.result     = a + b;
        case (opc)
            `OPC_LUI:   e.result = imm_u;
            `OPC_AUIPC: e.result = cur_pc + imm_u;
            `OPC_JAL: begin
                e.result         = cur_pc + 32'd4;
                e.redirect_valid = 1'b1;
                e.redirect_pc    = cur_pc + imm_j;
            end
            `OPC_JALR: begin
                ok               = (f3 == 3'd0);
                tgt              = a + imm_i;
                e.result         = cur_pc + 32'd4;
                e.redirect_valid = 1'b1;
                e.redirect_pc    = {tgt[31:1], 1'b0};
            end
            `OPC_BRANCH: begin
                ok               = (f3 != 3'd2 && f3 != 3'd3);
                e.result         = '0;
                e.redirect_valid = branch_cond(f3, a, b);
                e.redirect_pc    = e.redirect_valid ? cur_pc + imm_b : '0;
            end
            `OPC_LOAD: begin
                ok        = (f3 != 3'd3 && f3 < 3'd6);
                e.result  = a + imm_i;
                e.is_load = 1'b1;
            end
            `OPC_STORE: begin
                ok         = (f3 < 3'd3);
                e.result   = a + imm_s;
                e.is_store = 1'b1;
            end
            `OPC_OPIMM: begin
                if (f3 == 3'd1) begin
                    ok = (f7 == `F7_BASE);
                end else if (f3 == 3'd5) begin
                    ok = (f7 == `F7_BASE || f7 == `F7_ALT);
                end
                e.result = arith_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
            end
            `OPC_OP: begin
                ok       = (f7 == `F7_BASE) || (f7 == `F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
                e.result = arith_ref(f3, w[30], a, b);
            end
            `OPC_SYSTEM: begin
                if (w == `INST_ECALL || w == `INST_MRET) begin
                    e.redirect_valid = 1'b1;
                    e.redirect_pc    = csr;
                end else if (w == `INST_EBREAK) begin
                    e.halt = 1'b1;
                end else if (f3 == `F3_CSRRW || f3 == `F3_CSRRS) begin
                    e.result    = csr;
                    e.csr_wdata = (f3 == `F3_CSRRW) ? a : (a | csr);
                end else begin
                    ok = 1'b0;
                end
            end
            `OPC_MISCMEM: begin
                ok        = (f3 < 3'd2);
                e.fence_i = (f3 == 3'd1);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e            = '0;
            e.result     = a + b;
            e.store_data = b;
            e.rd         = rd_field;
            e.illegal    = 1'b1;
        end
        return e;
    endfunction

    // Build a word from a legal template or leave it fully random
    function automatic word_t random_inst();
        word_t      w;
        int         kind;
        logic [2:0] f3;
        w    = $random(seed);
        kind = $unsigned($random(seed)) % 14;
        f3   = w[14:12];
        case (kind)
            0: w[6:0] = `OPC_LUI;
            1: w[6:0] = `OPC_AUIPC;
            2: w[6:0] = `OPC_JAL;
            3: begin
                w[6:0]   = `OPC_JALR;
                w[14:12] = 3'd0;
            end
            4: begin
                // Fold the funct3 values 2 and 3 onto 6 and 7 since they are no branches
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                w[6:0]   = `OPC_BRANCH;
                w[14:12] = f3;
            end
            5: begin
                if (f3 == 3'd3 || f3 > 3'd5) begin
                    f3 = 3'd2;
                end
                w[6:0]   = `OPC_LOAD;
                w[14:12] = f3;
            end
            6: begin
                w[6:0] = `OPC_STORE;
                w[14]  = 1'b0;
                if (w[13:12] == 2'b11) begin
                    w[13] = 1'b0;
                end
            end
            7: begin
                w[6:0] = `OPC_OPIMM;
                if (f3 == 3'd1) begin
                    w[31:25] = `F7_BASE;
                end else if (f3 == 3'd5) begin
                    w[31:25] = w[30] ? `F7_ALT : `F7_BASE;
                end
            end
            8: begin
                w[6:0]   = `OPC_OP;
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? `F7_ALT : `F7_BASE;
            end
            9: begin
                w[6:0]   = `OPC_SYSTEM;
                w[14:12] = w[12] ? `F3_CSRRW : `F3_CSRRS;
            end
            10: begin
                case (f3[1:0])
                    2'd0:    w = `INST_ECALL;
                    2'd1:    w = `INST_EBREAK;
                    default: w = `INST_MRET;
                endcase
            end
            11: begin
                w[6:0]   = `OPC_MISCMEM;
                w[14:12] = {2'b00, f3[0]};
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_next();
        in_valid  = ($unsigned($random(seed)) % 8) != 0;
        inst      = random_inst();
        pc        = $random(seed) & 32'hffff_fffc;
        rs1_data  = $random(seed);
        rs2_data  = (($unsigned($random(seed)) % 4) == 0) ? rs1_data : $random(seed);
        csr_rdata = $random(seed);
    endtask

    task automatic check_field(input string name, input word_t exp_val, input word_t act_val);
        assert (exp_val == act_val) else begin
            $display("ERR %s expected %h got %h", name, exp_val, act_val);
            errors++;
        end
    endtask

    // The ready is passed straight back upstream
    always @(posedge clk) begin
        if (!rst) begin
            check_field("in_ready", word_t'(out_ready), word_t'(in_ready));
            if (in_valid && out_ready) begin
                exp_q.push_back(expected_out(inst, pc, rs1_data, rs2_data, csr_rdata));
            end
        end
    end

    always @(negedge clk) begin : compare_outputs
        exp_t e;
        if (!rst && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Output valid while no accepted instruction was waiting");
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_field("result", e.result, result);
                check_field("store_data", e.store_data, store_data);
                check_field("csr_wdata", e.csr_wdata, csr_wdata);
                check_field("rd", word_t'(e.rd), word_t'(rd));
                check_field("is_load", word_t'(e.is_load), word_t'(is_load));
                check_field("is_store", word_t'(e.is_store), word_t'(is_store));
                check_field("fence_i", word_t'(e.fence_i), word_t'(fence_i));
                check_field("redirect_valid", word_t'(e.redirect_valid),
                            word_t'(redirect_valid));
                check_field("redirect_pc", e.redirect_pc, redirect_pc);
                check_field("halt", word_t'(e.halt), word_t'(halt));
                check_field("illegal", word_t'(e.illegal), word_t'(illegal));
                checked++;
            end
        end else if (!rst) begin
            assert (!redirect_valid && !halt && !illegal && result == '0) else begin
                $display("Outputs were not cleared while out_valid was low");
                errors++;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        csr_rdata = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst  = 1'b0;
        sent = 0;
        while (sent < NUM_INSTR) begin
            drive_next();
            out_ready = ($unsigned($random(seed)) % 5) != 0;
            @(negedge clk);
            // Upstream holds the word until the stage takes it
            while (in_valid && !out_ready) begin
                out_ready = ($unsigned($random(seed)) % 5) != 0;
                @(negedge clk);
            end
            if (in_valid) begin
                sent++;
            end
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        assert (checked == NUM_INSTR) else begin
            $display("Expected %0d results but %0d came out", NUM_INSTR, checked);
            errors++;
        end
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the stage stopped producing results", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/exec_stage_asserts.sv */
`default_nettype none

module exec_stage_asserts (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_ready,
    input logic out_valid,
    input logic redirect_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // A result leaves exactly one cycle after its instruction was taken
    valid_after_accept: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid && out_ready))
        else $error("out_valid without an instruction accepted the cycle before");

    accept_gives_valid: assert property (@(posedge clk) disable iff (rst)
        (in_valid && out_ready) |=> out_valid)
        else $error("accepted instruction did not raise out_valid");

    redirect_in_valid: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> out_valid)
        else $error("redirect_valid high while out_valid is low");

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind exec_stage_top exec_stage_asserts exec_stage_asserts_inst (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .out_ready      (out_ready),
    .out_valid      (out_valid),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

/* design/exec_stage_top.sv */
`default_nettype none

module exec_stage_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  rv_core_pkg::word_t    inst,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::word_t    csr_rdata,
    input  logic                  out_ready,
    output logic                  in_ready,
    output logic                  out_valid,
    output rv_core_pkg::word_t    result,
    output rv_core_pkg::word_t    store_data,
    output rv_core_pkg::word_t    csr_wdata,
    output rv_core_pkg::reg_idx_t rd,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  fence_i,
    output logic                  redirect_valid,
    output rv_core_pkg::word_t    redirect_pc,
    output logic                  halt,
    output logic                  illegal
);
    import rv_core_pkg::*;

    word_t    dec_imm;
    alu_op_t  dec_alu_op;
    reg_idx_t dec_rd;
    logic     dec_src1_is_pc;
    logic     dec_src2_is_imm;
    logic     dec_is_jump;
    logic     dec_is_jalr;
    logic     dec_is_branch;
    logic     dec_is_load;
    logic     dec_is_store;
    logic     dec_fence_i;
    logic     dec_ecall;
    logic     dec_mret;
    logic     dec_ebreak;
    logic     dec_csrrw;
    logic     dec_csrrs;
    logic     dec_illegal;

    inst_decoder inst_decoder_inst (
        .inst        (inst),
        .imm         (dec_imm),
        .alu_op      (dec_alu_op),
        .src1_is_pc  (dec_src1_is_pc),
        .src2_is_imm (dec_src2_is_imm),
        .is_jump     (dec_is_jump),
        .is_jalr     (dec_is_jalr),
        .is_branch   (dec_is_branch),
        .is_load     (dec_is_load),
        .is_store    (dec_is_store),
        .fence_i     (dec_fence_i),
        .ecall       (dec_ecall),
        .mret        (dec_mret),
        .ebreak      (dec_ebreak),
        .csrrw       (dec_csrrw),
        .csrrs       (dec_csrrs),
        .illegal     (dec_illegal),
        .rd          (dec_rd)
    );

    exec_unit exec_unit_inst (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .imm            (dec_imm),
        .alu_op         (dec_alu_op),
        .src1_is_pc     (dec_src1_is_pc),
        .src2_is_imm    (dec_src2_is_imm),
        .is_jump        (dec_is_jump),
        .is_jalr        (dec_is_jalr),
        .is_branch      (dec_is_branch),
        .is_load        (dec_is_load),
        .is_store       (dec_is_store),
        .fence_i        (dec_fence_i),
        .ecall          (dec_ecall),
        .mret           (dec_mret),
        .ebreak         (dec_ebreak),
        .csrrw          (dec_csrrw),
        .csrrs          (dec_csrrs),
        .illegal        (dec_illegal),
        .rd             (dec_rd),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .csr_rdata      (csr_rdata),
        .out_valid      (out_valid),
        .result         (result),
        .store_data     (store_data),
        .csr_wdata      (csr_wdata),
        .rd_out         (rd),
        .is_load_out    (is_load),
        .is_store_out   (is_store),
        .fence_i_out    (fence_i),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halt           (halt),
        .illegal_out    (illegal)
    );

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`include "rv_core_params.svh"

`default_nettype none

module exec_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  out_ready,
    output logic                  in_ready,
    input  rv_core_pkg::word_t    imm,
    input  rv_core_pkg::alu_op_t  alu_op,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  is_jump,
    input  logic                  is_jalr,
    input  logic                  is_branch,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic                  fence_i,
    input  logic                  ecall,
    input  logic                  mret,
    input  logic                  ebreak,
    input  logic                  csrrw,
    input  logic                  csrrs,
    input  logic                  illegal,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::word_t    csr_rdata,
    output logic                  out_valid,
    output rv_core_pkg::word_t    result,
    output rv_core_pkg::word_t    store_data,
    output rv_core_pkg::word_t    csr_wdata,
    output rv_core_pkg::reg_idx_t rd_out,
    output logic                  is_load_out,
    output logic                  is_store_out,
    output logic                  fence_i_out,
    output logic                  redirect_valid,
    output rv_core_pkg::word_t    redirect_pc,
    output logic                  halt,
    output logic                  illegal_out
);
    import rv_core_pkg::*;

    word_t   src1;
    word_t   src2;
    word_t   alu_result;
    word_t   tgt_sum;
    word_t   next_result;
    word_t   next_csr_wdata;
    word_t   next_redirect_pc;
    alu_op_t cmp_op;
    logic    cmp_taken;
    logic    next_redirect;
    logic    accept;

    assign src1   = src1_is_pc ? pc : rs1_data;
    assign src2   = src2_is_imm ? imm : rs2_data;
    assign cmp_op = (is_branch || is_jump) ? alu_op : `ALU_ADD;

    alu alu_main (
        .alu_op     (alu_op),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .taken      ()
    );

    // Only the taken bit of this instance is used
    alu alu_cmp (
        .alu_op     (cmp_op),
        .src1       (rs1_data),
        .src2       (rs2_data),
        .alu_result (),
        .taken      (cmp_taken)
    );

    // Separate adder for the jump and branch target
    assign tgt_sum = (is_jalr ? rs1_data : pc) + imm;

    assign next_redirect    = cmp_taken || ecall || mret;
    assign next_redirect_pc = (ecall || mret) ? csr_rdata :
                              cmp_taken ? {tgt_sum[`RV_XLEN-1:1], tgt_sum[0] & !is_jalr} :
                              '0;

    assign next_result    = is_jump ? pc + 32'd4 :
                            (csrrw || csrrs) ? csr_rdata :
                            alu_result;
    assign next_csr_wdata = csrrw ? rs1_data :
                            csrrs ? (rs1_data | csr_rdata) :
                            '0;

    assign in_ready = out_ready;
    assign accept   = in_valid && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            result         <= '0;
            store_data     <= '0;
            csr_wdata      <= '0;
            rd_out         <= '0;
            is_load_out    <= 1'b0;
            is_store_out   <= 1'b0;
            fence_i_out    <= 1'b0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
            halt           <= 1'b0;
            illegal_out    <= 1'b0;
        end else if (accept) begin
            out_valid      <= 1'b1;
            result         <= next_result;
            store_data     <= rs2_data;
            csr_wdata      <= next_csr_wdata;
            rd_out         <= rd;
            is_load_out    <= is_load;
            is_store_out   <= is_store;
            fence_i_out    <= fence_i;
            redirect_valid <= next_redirect;
            redirect_pc    <= next_redirect_pc;
            halt           <= ebreak;
            illegal_out    <= illegal;
        end else begin
            // Outputs drop back to zero between accepted instructions
            out_valid      <= 1'b0;
            result         <= '0;
            store_data     <= '0;
            csr_wdata      <= '0;
            rd_out         <= '0;
            is_load_out    <= 1'b0;
            is_store_out   <= 1'b0;
            fence_i_out    <= 1'b0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
            halt           <= 1'b0;
            illegal_out    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`include "rv_core_params.svh"

`default_nettype none

module alu (
    input  rv_core_pkg::alu_op_t alu_op,
    input  rv_core_pkg::word_t   src1,
    input  rv_core_pkg::word_t   src2,
    output rv_core_pkg::word_t   alu_result,
    output logic                 taken
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = src2[4:0];
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    always_comb begin
        alu_result = '0;
        taken      = 1'b0;
        case (alu_op)
            `ALU_ADD:  alu_result = src1 + src2;
            `ALU_SUB:  alu_result = src1 - src2;
            `ALU_SLL:  alu_result = src1 << shamt;
            `ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            `ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            `ALU_XOR:  alu_result = src1 ^ src2;
            `ALU_SRL:  alu_result = src1 >> shamt;
            `ALU_SRA:  alu_result = word_t'($signed(src1) >>> shamt);
            `ALU_OR:   alu_result = src1 | src2;
            `ALU_AND:  alu_result = src1 & src2;
            `ALU_LUI:  alu_result = src2;
            // Compare ops leave the result at zero
            `ALU_BEQ:  taken = (src1 == src2);
            `ALU_BNE:  taken = (src1 != src2);
            `ALU_BLT:  taken = lt_s;
            `ALU_BGE:  taken = !lt_s;
            `ALU_BLTU: taken = lt_u;
            `ALU_BGEU: taken = !lt_u;
            `ALU_JUMP: taken = 1'b1;
            default:   alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`include "rv_core_params.svh"

`default_nettype none

module inst_decoder (
    input  rv_core_pkg::word_t    inst,
    output rv_core_pkg::word_t    imm,
    output rv_core_pkg::alu_op_t  alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  is_jump,
    output logic                  is_jalr,
    output logic                  is_branch,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  fence_i,
    output logic                  ecall,
    output logic                  mret,
    output logic                  ebreak,
    output logic                  csrrw,
    output logic                  csrrs,
    output logic                  illegal,
    output rv_core_pkg::reg_idx_t rd
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    // Map funct3 to an ALU op, alt selects sub or sra
    function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    f3_to_op = alt ? `ALU_SUB : `ALU_ADD;
            3'd1:    f3_to_op = `ALU_SLL;
            3'd2:    f3_to_op = `ALU_SLT;
            3'd3:    f3_to_op = `ALU_SLTU;
            3'd4:    f3_to_op = `ALU_XOR;
            3'd5:    f3_to_op = alt ? `ALU_SRA : `ALU_SRL;
            3'd6:    f3_to_op = `ALU_OR;
            default: f3_to_op = `ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = (opcode == `OPC_BRANCH || opcode == `OPC_STORE) ? 5'd0 : inst[11:7];

    always_comb begin
        imm         = '0;
        alu_op      = `ALU_ADD;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        is_jump     = 1'b0;
        is_jalr     = 1'b0;
        is_branch   = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        fence_i     = 1'b0;
        ecall       = 1'b0;
        mret        = 1'b0;
        ebreak      = 1'b0;
        csrrw       = 1'b0;
        csrrs       = 1'b0;
        bad         = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                imm         = {inst[31:12], 12'b0};
                alu_op      = `ALU_LUI;
                src2_is_imm = 1'b1;
            end
            `OPC_AUIPC: begin
                imm         = {inst[31:12], 12'b0};
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
            end
            `OPC_JAL: begin
                imm     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                alu_op  = `ALU_JUMP;
                is_jump = 1'b1;
            end
            `OPC_JALR: begin
                imm         = {{20{inst[31]}}, inst[31:20]};
                alu_op      = `ALU_JUMP;
                src2_is_imm = 1'b1;
                is_jump     = 1'b1;
                is_jalr     = 1'b1;
                bad         = (funct3 != 3'd0);
            end
            `OPC_BRANCH: begin
                imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                is_branch = 1'b1;
                case (funct3)
                    3'd0:    alu_op = `ALU_BEQ;
                    3'd1:    alu_op = `ALU_BNE;
                    3'd4:    alu_op = `ALU_BLT;
                    3'd5:    alu_op = `ALU_BGE;
                    3'd6:    alu_op = `ALU_BLTU;
                    3'd7:    alu_op = `ALU_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            `OPC_LOAD: begin
                imm         = {{20{inst[31]}}, inst[31:20]};
                src2_is_imm = 1'b1;
                is_load     = 1'b1;
                bad         = (funct3 == 3'd3 || funct3 > 3'd5);
            end
            `OPC_STORE: begin
                imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                src2_is_imm = 1'b1;
                is_store    = 1'b1;
                bad         = (funct3 > 3'd2);
            end
            `OPC_OPIMM: begin
                imm         = {{20{inst[31]}}, inst[31:20]};
                src2_is_imm = 1'b1;
                // Only the shifts look at funct7, and only srai may set bit 30
                alu_op      = f3_to_op(funct3, funct3 == 3'd5 && inst[30]);
                if (funct3 == 3'd1) begin
                    bad = (funct7 != `F7_BASE);
                end else if (funct3 == 3'd5) begin
                    bad = (funct7 != `F7_BASE && funct7 != `F7_ALT);
                end
            end
            `OPC_OP: begin
                alu_op = f3_to_op(funct3, funct7 == `F7_ALT);
                bad    = !(funct7 == `F7_BASE ||
                           (funct7 == `F7_ALT && (funct3 == 3'd0 || funct3 == 3'd5)));
            end
            `OPC_SYSTEM: begin
                if (inst == `INST_ECALL) begin
                    ecall = 1'b1;
                end else if (inst == `INST_EBREAK) begin
                    ebreak = 1'b1;
                end else if (inst == `INST_MRET) begin
                    mret = 1'b1;
                end else if (funct3 == `F3_CSRRW) begin
                    csrrw = 1'b1;
                end else if (funct3 == `F3_CSRRS) begin
                    csrrs = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            // Plain fence is a no-op here
            `OPC_MISCMEM: begin
                fence_i = (funct3 == 3'd1);
                bad     = (funct3 > 3'd1);
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            imm         = '0;
            alu_op      = `ALU_ADD;
            src1_is_pc  = 1'b0;
            src2_is_imm = 1'b0;
            is_jump     = 1'b0;
            is_jalr     = 1'b0;
            is_branch   = 1'b0;
            is_load     = 1'b0;
            is_store    = 1'b0;
            fence_i     = 1'b0;
        end
        illegal = bad;
    end

endmodule

`default_nettype wire

/* design/rv_core_pkg.sv */
`include "rv_core_params.svh"

`default_nettype none

package rv_core_pkg;

    // Data or address word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Encoded ALU operation
    typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;

    // Major opcode field
    typedef logic [6:0] opcode_t;

    // Register index
    typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

/* design/rv_core_params.svh */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

`default_nettype none

`define RV_XLEN         32
`define RV_ALU_OP_W     5

// Arithmetic and logic ops
`define ALU_ADD         5'd0
`define ALU_SUB         5'd1
`define ALU_SLL         5'd2
`define ALU_SLT         5'd3
`define ALU_SLTU        5'd4
`define ALU_XOR         5'd5
`define ALU_SRL         5'd6
`define ALU_SRA         5'd7
`define ALU_OR          5'd8
`define ALU_AND         5'd9
`define ALU_LUI         5'd10

// Compare ops only drive the taken bit
`define ALU_BEQ         5'd16
`define ALU_BNE         5'd17
`define ALU_BLT         5'd18
`define ALU_BGE         5'd19
`define ALU_BLTU        5'd20
`define ALU_BGEU        5'd21
`define ALU_JUMP        5'd22

`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OPIMM       7'b0010011
`define OPC_OP          7'b0110011
`define OPC_SYSTEM      7'b1110011
`define OPC_MISCMEM     7'b0001111

`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000
`define F3_CSRRW        3'b001
`define F3_CSRRS        3'b010

`define INST_ECALL      32'h0000_0073
`define INST_EBREAK     32'h0010_0073
`define INST_MRET       32'h3020_0073

`default_nettype wire

`endif
